//--- source/fir_pkg.sv
`default_nettype none

package fir_pkg;

	// address width shared by the sample and coefficient storages.
	localparam int ADDR_W = 9;

	// entries per storage.
	localparam int DEPTH = 512;

	// sample, coefficient and output word width.
	localparam int DATA_W = 16;

	// full signed product of two Q15 words.
	localparam int PROD_W = 32;

	// room for 512 full-scale products plus sign.
	localparam int ACC_W = 41;

	// fraction bits of a Q15 coefficient, also the output shift.
	localparam int FRAC_W = 15;

	// tap sequencer states.
	typedef enum logic [1:0] {
		S_IDLE  = 2'd0,
		S_RUN   = 2'd1,
		S_DRAIN = 2'd2
	} seq_state_t;

endpackage

`default_nettype wire

//--- source/filter_storage.sv
`timescale 1ns/100ps
`default_nettype none

module filter_storage
	import fir_pkg::*;
(
	input  logic              clk,
	input  logic              rstb,
	input  logic              wren,
	input  logic [ADDR_W-1:0] wrptr,
	input  logic [DATA_W-1:0] wrdata,
	input  logic              rden,
	input  logic [ADDR_W-1:0] rdptr,
	output logic [DATA_W-1:0] rddata
);

	logic [DATA_W-1:0] mem [DEPTH];

	// every entry is cleared by reset so an unwritten tap reads as zero.
	always_ff @(posedge clk or negedge rstb)
	begin
		if (!rstb)
		begin
			for (int i = 0; i < DEPTH; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (wren)
		begin
			mem[wrptr] <= wrdata;
		end
	end

	// registered read, holds its last word while rden is low.
	always_ff @(posedge clk)
	begin
		if (rden)
		begin
			rddata <= mem[rdptr];
		end
	end

endmodule

`default_nettype wire

//--- source/fir_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module fir_sequencer
	import fir_pkg::*;
(
	input  logic              clk,
	input  logic              rstb,
	input  logic              sample_valid,
	input  logic [DATA_W-1:0] sample_data,
	input  logic [ADDR_W-1:0] num_taps,
	output logic              smp_wren,
	output logic [ADDR_W-1:0] smp_wrptr,
	output logic [DATA_W-1:0] smp_wrdata,
	output logic              rden,
	output logic [ADDR_W-1:0] smp_rdptr,
	output logic [ADDR_W-1:0] coef_rdptr,
	output logic              acc_en,
	output logic              acc_first,
	output logic              acc_last,
	output logic              busy
);

	seq_state_t        state;
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] base_ptr;
	logic [ADDR_W-1:0] taps;
	logic [ADDR_W-1:0] k;
	logic              accept;
	logic              first_tap;
	logic              last_tap;
	logic              mac_done;

	// a sample offered while busy is dropped.
	assign accept = sample_valid && (state == S_IDLE);
	assign busy   = (state != S_IDLE);

	assign smp_wren   = accept;
	assign smp_wrptr  = wr_ptr;
	assign smp_wrdata = sample_data;

	// each S_RUN cycle reads sample x[n-k] and coefficient c[k] for tap k.
	assign rden       = (state == S_RUN);
	assign smp_rdptr  = base_ptr - k;
	assign coef_rdptr = k;

	assign first_tap = (k == '0);
	assign last_tap  = (k == taps);

	// circular write pointer for the sample history.
	always_ff @(posedge clk or negedge rstb)
	begin
		if (!rstb)
		begin
			wr_ptr <= '0;
		end
		else if (accept)
		begin
			// the 9-bit pointer wraps from 511 back to 0 by itself.
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rstb)
	begin
		if (!rstb)
		begin
			state    <= S_IDLE;
			base_ptr <= '0;
			taps     <= '0;
			k        <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (accept)
					begin
						state    <= S_RUN;
						base_ptr <= wr_ptr;
						taps     <= num_taps;
						k        <= '0;
					end
				end
				S_RUN:
				begin
					if (last_tap)
						state <= S_DRAIN;
					else
						k <= k + 1'b1;
				end
				S_DRAIN:
				begin
					// wait out the last accumulate and the output register.
					if (mac_done)
						state <= S_IDLE;
				end
				default:
				begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// tap flags follow the read data one cycle behind rden.
	always_ff @(posedge clk or negedge rstb)
	begin
		if (!rstb)
		begin
			acc_en    <= 1'b0;
			acc_first <= 1'b0;
			acc_last  <= 1'b0;
			mac_done  <= 1'b0;
		end
		else
		begin
			acc_en    <= rden;
			acc_first <= rden && first_tap;
			acc_last  <= rden && last_tap;
			mac_done  <= acc_last;
		end
	end

endmodule

`default_nettype wire

//--- source/fir_mac.sv
`timescale 1ns/100ps
`default_nettype none

module fir_mac
	import fir_pkg::*;
(
	input  logic              clk,
	input  logic              rstb,
	input  logic [DATA_W-1:0] sample_word,
	input  logic [DATA_W-1:0] coef_word,
	input  logic              acc_en,
	input  logic              acc_first,
	input  logic              acc_last,
	output logic              out_valid,
	output logic [DATA_W-1:0] out_data,
	output logic              sat
);

	logic signed [PROD_W-1:0] product;
	logic signed [ACC_W-1:0]  acc;
	logic signed [ACC_W-1:0]  scaled;
	logic                     sum_done;
	logic                     fits;
	logic [DATA_W-1:0]        clipped;

	// Q15 times Q15 gives a Q30 product.
	assign product = $signed(sample_word) * $signed(coef_word);

	// floor division by 2^15.
	assign scaled = acc >>> FRAC_W;

	// the result fits when every bit above the output sign copies it.
	assign fits = (scaled[ACC_W-1:DATA_W-1] == {(ACC_W-DATA_W+1){scaled[ACC_W-1]}});

	// clip to 32767 or -32768 by the sign of the sum.
	assign clipped = fits ? scaled[DATA_W-1:0]
	                      : {scaled[ACC_W-1], {(DATA_W-1){~scaled[ACC_W-1]}}};

	// tap 0 loads the accumulator, later taps add to it.
	always_ff @(posedge clk)
	begin
		if (acc_en)
		begin
			if (acc_first)
				acc <= ACC_W'(product);
			else
				acc <= acc + ACC_W'(product);
		end
	end

	always_ff @(posedge clk or negedge rstb)
	begin
		if (!rstb)
		begin
			sum_done <= 1'b0;
		end
		else
		begin
			sum_done <= acc_en && acc_last;
		end
	end

	// the finished sum is scaled one cycle after its last add.
	always_ff @(posedge clk or negedge rstb)
	begin
		if (!rstb)
		begin
			out_valid <= 1'b0;
			out_data  <= '0;
			sat       <= 1'b0;
		end
		else
		begin
			out_valid <= sum_done;
			if (sum_done)
			begin
				out_data <= clipped;
				sat      <= !fits;
			end
			else
			begin
				sat <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/fir_top.sv
`timescale 1ns/100ps
`default_nettype none

module fir_top
	import fir_pkg::*;
(
	input  logic              clk,
	input  logic              rstb,
	input  logic              coef_wren,
	input  logic [ADDR_W-1:0] coef_addr,
	input  logic [DATA_W-1:0] coef_data,
	input  logic [ADDR_W-1:0] num_taps,
	input  logic              sample_valid,
	input  logic [DATA_W-1:0] sample_data,
	output logic              busy,
	output logic              out_valid,
	output logic [DATA_W-1:0] out_data,
	output logic              sat
);

	logic              smp_wren;
	logic [ADDR_W-1:0] smp_wrptr;
	logic [DATA_W-1:0] smp_wrdata;
	logic              rden;
	logic [ADDR_W-1:0] smp_rdptr;
	logic [ADDR_W-1:0] coef_rdptr;
	logic [DATA_W-1:0] sample_word;
	logic [DATA_W-1:0] coef_word;
	logic              acc_en;
	logic              acc_first;
	logic              acc_last;

	fir_sequencer seq0 (
		.clk          (clk),
		.rstb         (rstb),
		.sample_valid (sample_valid),
		.sample_data  (sample_data),
		.num_taps     (num_taps),
		.smp_wren     (smp_wren),
		.smp_wrptr    (smp_wrptr),
		.smp_wrdata   (smp_wrdata),
		.rden         (rden),
		.smp_rdptr    (smp_rdptr),
		.coef_rdptr   (coef_rdptr),
		.acc_en       (acc_en),
		.acc_first    (acc_first),
		.acc_last     (acc_last),
		.busy         (busy)
	);

	// sample history, written as a circular buffer.
	filter_storage smp_store0 (
		.clk    (clk),
		.rstb   (rstb),
		.wren   (smp_wren),
		.wrptr  (smp_wrptr),
		.wrdata (smp_wrdata),
		.rden   (rden),
		.rdptr  (smp_rdptr),
		.rddata (sample_word)
	);

	// coefficients, written directly by the host.
	filter_storage coef_store0 (
		.clk    (clk),
		.rstb   (rstb),
		.wren   (coef_wren),
		.wrptr  (coef_addr),
		.wrdata (coef_data),
		.rden   (rden),
		.rdptr  (coef_rdptr),
		.rddata (coef_word)
	);

	fir_mac mac0 (
		.clk         (clk),
		.rstb        (rstb),
		.sample_word (sample_word),
		.coef_word   (coef_word),
		.acc_en      (acc_en),
		.acc_first   (acc_first),
		.acc_last    (acc_last),
		.out_valid   (out_valid),
		.out_data    (out_data),
		.sat         (sat)
	);

endmodule

`default_nettype wire

//--- verif/fir_chk.sv
`timescale 1ns/100ps
`default_nettype none

module fir_chk
	import fir_pkg::*;
(
	input logic              clk,
	input logic              rstb,
	input logic              sample_valid,
	input logic              busy,
	input logic              out_valid,
	input logic [DATA_W-1:0] out_data,
	input logic              sat
);

	// a result is a single-cycle pulse.
	assert property (@(posedge clk) disable iff (!rstb) out_valid |=> !out_valid)
		else $error("out_valid high on two cycles in a row");

	assert property (@(posedge clk) disable iff (!rstb) out_valid |-> $past(busy))
		else $error("out_valid without busy in the cycle before");

	assert property (@(posedge clk) disable iff (!rstb) (sample_valid && !busy) |=> busy)
		else $error("accepted sample did not raise busy");

	// sat only qualifies a result.
	assert property (@(posedge clk) disable iff (!rstb) sat |-> out_valid)
		else $error("sat high without out_valid");

	assert property (@(posedge clk) disable iff (!rstb) !out_valid |-> $stable(out_data))
		else $error("out_data changed between results");

endmodule

bind fir_top fir_chk chk0 (
	.clk          (clk),
	.rstb         (rstb),
	.sample_valid (sample_valid),
	.busy         (busy),
	.out_valid    (out_valid),
	.out_data     (out_data),
	.sat          (sat)
);

`default_nettype wire

//--- verif/tb_fir.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fir
	import fir_pkg::*;
();

	logic              clk;
	logic              rstb;
	logic              coef_wren;
	logic [ADDR_W-1:0] coef_addr;
	logic [DATA_W-1:0] coef_data;
	logic [ADDR_W-1:0] num_taps;
	logic              sample_valid;
	logic [DATA_W-1:0] sample_data;
	logic              busy;
	logic              out_valid;
	logic [DATA_W-1:0] out_data;
	logic              sat;

	// shadow copies of both storages.
	int          coef_model [DEPTH];
	int          hist_model [DEPTH];
	int          wp_model;
	int          base_model;
	int          taps_model;
	int unsigned lcg_state;

	fir_top dut0 (
		.clk          (clk),
		.rstb         (rstb),
		.coef_wren    (coef_wren),
		.coef_addr    (coef_addr),
		.coef_data    (coef_data),
		.num_taps     (num_taps),
		.sample_valid (sample_valid),
		.sample_data  (sample_data),
		.busy         (busy),
		.out_valid    (out_valid),
		.out_data     (out_data),
		.sat          (sat)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// signed 16-bit value from the upper half of the LCG state.
	function automatic int next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'($signed(lcg_state[31:16]));
	endfunction

	// sum of history times coefficient floored by 2^15 and clipped.
	function automatic int model_output(output int clip);
		longint sum;
		longint q;
		sum = 0;
		for (int k = 0; k <= taps_model; k++)
			sum += longint'(hist_model[(base_model - k + DEPTH) % DEPTH]) *
				longint'(coef_model[k]);
		q = sum >>> FRAC_W;
		clip = (q > 32767 || q < -32768) ? 1 : 0;
		if (q > 32767)
			q = 32767;
		else if (q < -32768)
			q = -32768;
		return int'(q);
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected !== actual)
		begin
			stop_run($sformatf("Error at %0t: %s expected %0d, got %0d",
				$time, name, expected, actual));
		end
	endtask

	task automatic write_coef(input int addr, input int value);
		coef_wren = 1'b1;
		coef_addr = ADDR_W'(addr);
		coef_data = DATA_W'(value);
		@(posedge clk);
		#2;
		coef_wren = 1'b0;
		coef_model[addr] = value;
	endtask

	task automatic await_idle();
		int n;
		n = 0;
		while (busy)
		begin
			@(posedge clk);
			#2;
			n++;
			if (n > 1000)
				stop_run("Timeout: busy never returned low");
		end
	endtask

	task automatic send_sample(input int value, input int taps);
		await_idle();
		sample_valid = 1'b1;
		sample_data  = DATA_W'(value);
		num_taps     = ADDR_W'(taps);
		@(posedge clk);
		#2;
		sample_valid = 1'b0;
		hist_model[wp_model] = value;
		base_model = wp_model;
		taps_model = taps;
		wp_model = (wp_model + 1) % DEPTH;
		check_value("busy", 1, int'(busy));
	endtask

	// elapsed counts the edges already passed since acceptance.
	task automatic collect_output(input int elapsed);
		int edges;
		int exp_data;
		int exp_sat;
		edges = elapsed;
		while (!out_valid)
		begin
			@(posedge clk);
			#2;
			edges++;
			if (edges > 1000)
				stop_run("Timeout: no out_valid after an accepted sample");
		end
		exp_data = model_output(exp_sat);
		check_value("latency", taps_model + 3, edges);
		check_value("out_data", exp_data, int'($signed(out_data)));
		check_value("sat", exp_sat, int'(sat));
	endtask

	task automatic run_sample(input int value, input int taps);
		send_sample(value, taps);
		collect_output(0);
	endtask

	task automatic reset_values();
		check_value("busy", 0, int'(busy));
		check_value("out_valid", 0, int'(out_valid));
		check_value("sat", 0, int'(sat));
		check_value("out_data", 0, int'($signed(out_data)));
		// cleared coefficients give a zero sum.
		run_sample(1234, 3);
		check_value("out_data", 0, int'($signed(out_data)));
	endtask

	task automatic impulse_response();
		int c [8];
		c = '{16384, -8192, 32767, -32768, 1000, -1, 0, 3};
		for (int k = 0; k < 8; k++)
			write_coef(k, c[k]);
		// flush older samples out of the 8-tap window.
		for (int i = 0; i < 8; i++)
			run_sample(0, 7);
		for (int i = 0; i < 8; i++)
		begin
			run_sample((i == 0) ? 32767 : 0, 7);
			check_value("out_data", (32767 * c[i]) >>> FRAC_W, int'($signed(out_data)));
		end
	endtask

	task automatic random_stream();
		int value;
		int taps;
		for (int k = 0; k < 32; k++)
			write_coef(k, next_rand());
		for (int i = 0; i < 40; i++)
		begin
			value = next_rand();
			taps = next_rand() & 31;
			run_sample(value, taps);
		end
	endtask

	task automatic saturation_cases();
		for (int k = 0; k < 8; k++)
			write_coef(k, 32767);
		for (int i = 0; i < 8; i++)
			run_sample(32767, 7);
		check_value("out_data", 32767, int'($signed(out_data)));
		check_value("sat", 1, int'(sat));
		for (int i = 0; i < 8; i++)
			run_sample(-32768, 7);
		check_value("out_data", -32768, int'($signed(out_data)));
		check_value("sat", 1, int'(sat));
		run_sample(100, 0);
		check_value("out_data", 99, int'($signed(out_data)));
		check_value("sat", 0, int'(sat));
	endtask

	task automatic back_pressure();
		send_sample(next_rand(), 15);
		// a sample offered while busy must be dropped.
		sample_data = 16'h5a5a;
		for (int i = 0; i < 4; i++)
		begin
			sample_valid = 1'b1;
			@(posedge clk);
			#2;
			check_value("busy", 1, int'(busy));
		end
		sample_valid = 1'b0;
		collect_output(4);
		for (int i = 0; i < 20; i++)
		begin
			@(posedge clk);
			#2;
			check_value("out_valid", 0, int'(out_valid));
		end
		run_sample(next_rand(), 15);
	endtask

	task automatic long_filter();
		for (int k = 0; k < DEPTH; k++)
			write_coef(k, next_rand() / 16);
		// wrap the write pointer once before the full-length runs.
		for (int i = 0; i < DEPTH + 8; i++)
			run_sample(next_rand(), 0);
		run_sample(next_rand(), DEPTH - 1);
		run_sample(next_rand(), DEPTH - 1);
	endtask

	initial
	begin
		rstb         = 1'b0;
		coef_wren    = 1'b0;
		coef_addr    = '0;
		coef_data    = '0;
		num_taps     = '0;
		sample_valid = 1'b0;
		sample_data  = '0;
		lcg_state    = 32'd52;
		wp_model     = 0;
		base_model   = 0;
		taps_model   = 0;
		for (int i = 0; i < DEPTH; i++)
		begin
			coef_model[i] = 0;
			hist_model[i] = 0;
		end
		repeat (3) @(posedge clk);
		#2;
		rstb = 1'b1;

		reset_values();
		impulse_response();
		random_stream();
		saturation_cases();
		back_pressure();
		long_filter();

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
source/fir_pkg.sv
source/filter_storage.sv
source/fir_sequencer.sv
source/fir_mac.sv
source/fir_top.sv
verif/fir_chk.sv
verif/tb_fir.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FIR filter testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f sim.f --top-module tb_fir -Mdir obj_dir -o tb_fir > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/tb_fir > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
	echo "FAIL"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

echo "PASS"
exit 0
